//--- bench/tb_tx_control.sv
// testbench for tx_control_top, apb setup, vector replay, checks and watchdog
`default_nettype none

module tb_tx_control;
  timeunit 1ns;
  timeprecision 1ps;
  import ctl_cfg_pkg::*;
  import mac_frame_pkg::*;

  // fixed configuration, times in clock cycles
  localparam logic [47:0] SELF_MAC = 48'h0011_2233_4455;
  localparam int SIFS = 10;
  localparam int PRE_SIG = 20;
  localparam int SYM = 4;
  localparam int SEND_WAIT = 5;
  localparam int SIG_TO = 20;
  localparam int ACK_TO = 30;
  localparam int LIMIT = 2;
  localparam int WAIT_MAX = 300;

  logic clk;
  logic rstn;
  apb_req_t apb_req;
  apb_rsp_t apb_rsp;
  rx_meta_t rx;
  logic sig_valid;
  phy_word_t word;
  logic word_valid;
  logic word_ready;
  logic ack_cts_busy;
  logic tx_done;
  logic tx_need_ack;
  logic backoff_done;
  logic quit_retrans;
  logic tx_try_complete;
  logic retrans_trigger;
  logic start_retrans;
  logic retrans_in_progress;

  int val_errs;
  int tmo_errs;
  int checks;
  int num_vec;
  string lines[$];

  tx_control_top dut0 (
    .clk(clk), .rstn(rstn), .apb_req(apb_req), .apb_rsp(apb_rsp), .rx(rx),
    .sig_valid(sig_valid), .word(word), .word_valid(word_valid), .word_ready(word_ready),
    .ack_cts_busy(ack_cts_busy), .tx_done(tx_done), .tx_need_ack(tx_need_ack),
    .backoff_done(backoff_done), .quit_retrans(quit_retrans),
    .tx_try_complete(tx_try_complete), .retrans_trigger(retrans_trigger),
    .start_retrans(start_retrans), .retrans_in_progress(retrans_in_progress)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // phy back-pressure, random once out of reset
  always @(posedge clk) begin
    word_ready <= rstn ? 1'($urandom % 2) : 1'b0;
  end

  // compare helper, counts every check
  task automatic check_val(input logic [63:0] got, input logic [63:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      val_errs++;
      $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
    @(posedge clk);
    apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
    @(posedge clk);
    apb_req.penable <= 1'b1;
    @(posedge clk);
    apb_req <= '0;
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
    @(posedge clk);
    apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: 32'd0};
    @(posedge clk);
    apb_req.penable <= 1'b1;
    // access phase, response settled mid cycle
    @(negedge clk);
    data = apb_rsp.prdata;
    err = apb_rsp.pslverr;
    // no wait states on this slave
    check_val(64'(apb_rsp.pready), 64'd1, "pready");
    @(posedge clk);
    apb_req <= '0;
  endtask

  task automatic pulse_tx_done();
    @(posedge clk);
    tx_done <= 1'b1;
    @(posedge clk);
    tx_done <= 1'b0;
  endtask

  // SIGNAL of ack length, then optionally the ack itself
  task automatic send_sig_and_ack(input logic with_ack);
    @(posedge clk);
    sig_valid <= 1'b1;
    rx.signal_len <= 16'd14;
    @(posedge clk);
    sig_valid <= 1'b0;
    rx <= '0;
    if (with_ack) begin
      rx <= '{fcs_strobe: 1'b1, fcs_valid: 1'b1, fc_type: FC_CTRL, fc_subtype: 4'hd,
              more_frag: 1'b0, duration: 16'd0, addr1: SELF_MAC, addr2: 48'h0,
              signal_len: 16'd14};
      @(posedge clk);
      rx <= '0;
    end
  endtask

  // 0 complete, 1 retrans_trigger, 2 timed out
  task automatic wait_outcome(output int kind, output int cycles);
    kind = 2;
    cycles = 0;
    while (kind == 2 && cycles < WAIT_MAX) begin
      @(negedge clk);
      cycles++;
      if (tx_try_complete) kind = 0;
      else if (retrans_trigger) kind = 1;
    end
    if (kind == 2) begin
      tmo_errs++;
      $display("no tx_try_complete or retrans_trigger seen within %0d cycles", WAIT_MAX);
    end
  endtask

  task automatic run_rx(input logic [47:0] f[0:10]);
    logic [63:0] exp_w[0:2];
    int n;
    int idx;
    int busy_at;
    // 6 mb/s code, length 14, even parity bit clear
    exp_w[0] = 64'h0000_0000_0000_01cb;
    exp_w[1] = {f[5][31:0], f[10][15:0], 8'h00, f[9][3:0], 2'b01, 2'b00};
    exp_w[2] = {48'd0, f[5][47:32]};
    apb_write(REG_CTRL, 32'(LIMIT) | (32'(f[7][0]) << 9));
    @(posedge clk);
    rx <= '{fcs_strobe: 1'b1, fcs_valid: f[3][0], fc_type: fc_type_t'(f[0][1:0]),
            fc_subtype: f[1][3:0], more_frag: f[2][0], duration: f[6][15:0],
            addr1: f[4], addr2: f[5], signal_len: 16'd0};
    n = 0;
    busy_at = 0;
    while (n < 40 && !word_valid) begin
      @(negedge clk);
      n++;
      if (ack_cts_busy && busy_at == 0) busy_at = n;
      if (n == 1) begin
        @(posedge clk);
        rx <= '0;
      end
    end
    if (f[8] == 0) begin
      checks++;
      if (word_valid || busy_at != 0) begin
        val_errs++;
        $display("ERR %0t: response started for a frame that needs none", $time);
      end
    end else begin
      // strobe cycle, then req one cycle later, then wait+1
      check_val(64'(n), 64'(SEND_WAIT + 3), "cycles to first word_valid");
      // busy rises the cycle after the request
      check_val(64'(busy_at), 64'd3, "cycles to ack_cts_busy");
      idx = 0;
      n = 0;
      while (idx < 3 && n < WAIT_MAX) begin
        if (word_valid && word_ready) begin
          check_val(word, exp_w[idx], $sformatf("word %0d", idx));
          idx++;
        end
        @(negedge clk);
        n++;
      end
      if (idx < 3) begin
        tmo_errs++;
        $display("response words did not finish within %0d cycles", WAIT_MAX);
      end else begin
        // one cycle past the last transfer
        check_val(64'(ack_cts_busy), 64'd0, "ack_cts_busy after word 2");
      end
    end
  endtask

  task automatic run_tx(input logic need_ack, input int misses, input logic quit,
                        input logic exp_ok, input int exp_retr);
    int attempt;
    int kind;
    int cyc;
    logic [31:0] rd;
    logic err;
    attempt = 0;
    kind = 1;
    tx_need_ack <= need_ack;
    pulse_tx_done();
    if (!need_ack) begin
      wait_outcome(kind, cyc);
      check_val(64'(cyc), 64'd1, "cycles to tx_try_complete");
    end else begin
      while (kind == 1) begin
        send_sig_and_ack(attempt >= misses);
        wait_outcome(kind, cyc);
        if (kind == 1) begin
          attempt++;
          check_val(64'(retrans_in_progress), 64'd1, "retrans_in_progress during retry");
          if (quit) begin
            @(posedge clk);
            quit_retrans <= 1'b1;
            @(posedge clk);
            quit_retrans <= 1'b0;
            wait_outcome(kind, cyc);
          end else begin
            @(posedge clk);
            backoff_done <= 1'b1;
            @(posedge clk);
            backoff_done <= 1'b0;
            @(negedge clk);
            check_val(64'(start_retrans), 64'd1, "start_retrans after backoff_done");
            pulse_tx_done();
          end
        end
      end
    end
    check_val(64'(retrans_in_progress), 64'd0, "retrans_in_progress after completion");
    tx_need_ack <= 1'b0;
    check_val(64'(attempt), 64'(exp_retr), "retrans_trigger count");
    apb_read(REG_STATUS, rd, err);
    check_val(64'(rd[4]), 64'(exp_ok), "status success");
    check_val(64'(rd[3:0]), 64'(exp_retr), "status num_retrans");
    check_val(64'(err), 64'd0, "status pslverr");
  endtask

  initial begin
    int fd;
    int got;
    string line;
    byte kind;
    logic [47:0] f[0:10];
    logic [31:0] rd;
    logic err;
    rstn = 1'b0;
    apb_req = '0;
    rx = '0;
    sig_valid = 1'b0;
    word_ready = 1'b0;
    tx_done = 1'b0;
    tx_need_ack = 1'b0;
    backoff_done = 1'b0;
    quit_retrans = 1'b0;
    val_errs = 0;
    tmo_errs = 0;
    checks = 0;
    void'($urandom(32'h96f9213b));
    fd = $fopen("bench/tx_control_vectors.txt", "r");
    if (fd == 0) begin
      $display("could not open the vector file bench/tx_control_vectors.txt");
      $display(">>> FAIL");
      $finish;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        got = $fgets(line, fd);
        if (got > 1 && line[0] != "#") lines.push_back(line);
      end
      $fclose(fd);
      num_vec = lines.size();
      repeat (3) @(posedge clk);
      rstn <= 1'b1;
      apb_write(REG_MAC_LO, SELF_MAC[31:0]);
      apb_write(REG_MAC_HI, {16'd0, SELF_MAC[47:32]});
      apb_write(REG_TIMING, (32'(SYM) << 16) | (32'(PRE_SIG) << 8) | 32'(SIFS));
      apb_write(REG_ACK_WAIT, 32'(SEND_WAIT));
      apb_write(REG_SIG_TO, 32'(SIG_TO));
      apb_write(REG_ACK_TO, 32'(ACK_TO));
      apb_write(REG_CTRL, 32'(LIMIT));
      foreach (lines[i]) begin
        f = '{default: '0};
        got = $sscanf(lines[i], "%c %h %h %h %h %h %h %h %h %h %h %h", kind, f[0], f[1],
                      f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10]);
        if (kind == "R") begin
          run_rx(f);
        end else if (kind == "T") begin
          run_tx(f[0][0], int'(f[1]), f[2][0], f[3][0], int'(f[4]));
        end else if (kind == "A") begin
          apb_read(f[0][7:0], rd, err);
          check_val(64'(err), 64'(f[1][0]), $sformatf("pslverr at offset %h", f[0][7:0]));
        end
      end
      $display("checks %0d, value errors %0d, timeouts %0d", checks, val_errs, tmo_errs);
      if (val_errs == 0 && tmo_errs == 0 && checks > 0) begin
        $display(">>> PASS");
      end else begin
        $display(">>> FAIL");
      end
      $finish;
    end
  end

  // watchdog scaled by the vector count
  initial begin
    wait (num_vec > 0);
    repeat (num_vec * 500) @(posedge clk);
    $display("simulation ran out of time after %0d vectors worth of cycles", num_vec);
    $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- bench/tx_control_vectors.txt
# R type subtype more_frag fcs_valid addr1 addr2 duration cts_disable | words subtype duration
# T need_ack missed_acks quit | success num_retrans ;  A offset | pslverr
R 2 0 1 1 001122334455 a0b0c0d0e0f0 0100 0 3 d 00ca
R 2 0 0 1 001122334455 a0b0c0d0e0f1 0100 0 3 d 0000
R 2 0 1 1 001122334455 a0b0c0d0e0f2 0020 0 3 d 0000
R 2 0 1 1 001122334455 a0b0c0d0e0f3 8005 0 3 d 0000
R 0 0 1 1 001122334455 a0b0c0d0e0f4 0040 0 3 d 000a
R 0 0 0 1 001122334455 a0b0c0d0e0f5 0050 0 3 d 0000
R 0 e 0 1 001122334455 a0b0c0d0e0f6 0050 0 0 0 0000
R 1 a 0 1 001122334455 a0b0c0d0e0f7 c001 0 3 d 0000
R 1 b 0 1 001122334455 0a0b0c0d0e0f 0200 0 3 c 01ca
R 1 b 0 1 001122334455 0a0b0c0d0e10 0036 0 3 c 0000
R 1 b 0 1 001122334455 0a0b0c0d0e11 0200 1 0 0 0000
R 2 0 0 0 001122334455 a0b0c0d0e0f8 0100 0 0 0 0000
R 2 0 0 1 001122334466 a0b0c0d0e0f9 0100 0 0 0 0000
R 2 0 1 1 001122334455 5566778899aa 0fff 0 3 d 0fc9
T 0 0 0 1 0
T 1 0 0 1 0
T 1 1 0 1 1
T 1 2 0 1 2
T 1 3 0 0 2
T 1 1 1 0 1
T 0 0 0 1 0
A 20 1
A 1c 0
A 40 1
A ff 1

//--- design/ack_responder.sv
// stage 2, response delay and three-word ack/cts stream to the phy
`default_nettype none

module ack_responder #(
  parameter int COUNT_WIDTH = 15
) (
  input wire clk,
  input wire rstn,
  input wire mac_frame_pkg::resp_req_t req,
  input wire ctl_cfg_pkg::ctl_cfg_t cfg,
  output mac_frame_pkg::phy_word_t word,
  output logic word_valid,
  input wire word_ready,
  output logic ack_cts_busy
);
  import mac_frame_pkg::*;

  // even parity over rate and length
  localparam logic SIG_PARITY = ^{ACK_RATE_CODE, ACK_SIGNAL_LEN};

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WAIT,
    ST_SEND
  } state_t;

  state_t state;
  logic [COUNT_WIDTH-1:0] wait_cnt;
  logic [1:0] word_idx;
  logic xfer;
  logic is_cts;
  logic [47:0] ra;
  logic [15:0] duration;
  sig_word_t sig_word;
  hdr_word_t hdr_word;

  assign word_valid = (state == ST_SEND);
  assign ack_cts_busy = (state != ST_IDLE);
  assign xfer = word_valid && word_ready;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state <= ST_IDLE;
      wait_cnt <= '0;
      word_idx <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          // requests during a response never reach here
          if (req.valid) begin
            wait_cnt <= cfg.send_ack_wait;
            word_idx <= '0;
            state <= (cfg.send_ack_wait == '0) ? ST_SEND : ST_WAIT;
          end
        end
        ST_WAIT: begin
          // first word_valid lands send_ack_wait+1 after the request
          wait_cnt <= wait_cnt - 1'b1;
          if (wait_cnt == COUNT_WIDTH'(1)) begin
            state <= ST_SEND;
          end
        end
        ST_SEND: begin
          if (xfer) begin
            word_idx <= word_idx + 1'b1;
            if (word_idx == 2'd2) begin
              state <= ST_IDLE;
            end
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // request payload
  always_ff @(posedge clk) begin
    if (state == ST_IDLE && req.valid) begin
      is_cts <= req.is_cts;
      ra <= req.ra;
      duration <= req.duration;
    end
  end

  // words built from latched fields, so they hold under back-pressure
  always_comb begin
    sig_word = '0;
    sig_word.parity = SIG_PARITY;
    sig_word.len = ACK_SIGNAL_LEN;
    sig_word.rate = ACK_RATE_CODE;
    hdr_word = '0;
    hdr_word.ra_lo = ra[31:0];
    hdr_word.duration = duration;
    hdr_word.subtype = is_cts ? SUBTYPE_CTS : SUBTYPE_ACK;
    hdr_word.ftype = FC_CTRL;
    case (word_idx)
      2'd0: word = sig_word;
      2'd1: word = hdr_word;
      default: word = {48'd0, ra[47:32]};
    endcase
  end

  // a stalled word stays put until the phy takes it
  a_word_hold: assert property (@(posedge clk) disable iff (!rstn)
    word_valid && !word_ready |=> word_valid && $stable(word));

endmodule

`default_nettype wire

//--- design/ack_wait_tracker.sv
// stage 3, ack reception fsm, retry counting and retransmission start
`default_nettype none

module ack_wait_tracker #(
  parameter int COUNT_WIDTH = 15,
  parameter int RETRY_WIDTH = 4
) (
  input wire clk,
  input wire rstn,
  input wire ctl_cfg_pkg::ctl_cfg_t cfg,
  input wire tx_done,
  input wire tx_need_ack,
  input wire sig_seen,
  input wire ack_seen,
  input wire backoff_done,
  input wire quit_retrans,
  input wire ack_cts_busy,
  output logic tx_try_complete,
  output logic retrans_trigger,
  output logic start_retrans,
  output logic retrans_in_progress,
  output ctl_cfg_pkg::tx_status_t status
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WAIT_SIG,
    ST_WAIT_ACK,
    ST_BACKOFF
  } state_t;

  state_t state;
  logic [COUNT_WIDTH-1:0] tmo_cnt;
  logic [RETRY_WIDTH-1:0] num_retrans;
  logic tx_start;
  logic out_of_retries;
  logic done_ok;
  logic give_up;
  logic timed_out;
  logic finish;
  logic retry;

  // own responses finish with tx_done too, skip those
  assign tx_start = tx_done && !ack_cts_busy;
  assign out_of_retries = (num_retrans == cfg.retrans_limit) || (cfg.retrans_limit == '0);

  // outcome of this cycle
  always_comb begin
    done_ok = 1'b0;
    give_up = 1'b0;
    timed_out = 1'b0;
    case (state)
      ST_IDLE: begin
        done_ok = tx_start && !tx_need_ack;
        // host abort between retries
        give_up = !tx_start && quit_retrans && retrans_in_progress;
      end
      ST_WAIT_SIG: timed_out = !sig_seen && (tmo_cnt == cfg.sig_valid_timeout);
      ST_WAIT_ACK: begin
        done_ok = ack_seen;
        timed_out = !ack_seen && (tmo_cnt == cfg.ack_timeout);
      end
      ST_BACKOFF: give_up = quit_retrans;
      default: ;
    endcase
  end

  assign finish = done_ok || give_up || (timed_out && out_of_retries);
  assign retry = timed_out && !out_of_retries;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state <= ST_IDLE;
      tmo_cnt <= '0;
      num_retrans <= '0;
      retrans_in_progress <= 1'b0;
      tx_try_complete <= 1'b0;
      retrans_trigger <= 1'b0;
      start_retrans <= 1'b0;
      status <= '0;
    end else begin
      tx_try_complete <= finish;
      retrans_trigger <= retry;
      start_retrans <= 1'b0;
      // timer runs only while waiting, restarts per phase
      if ((state == ST_WAIT_SIG && !sig_seen) || state == ST_WAIT_ACK) begin
        tmo_cnt <= tmo_cnt + 1'b1;
      end else begin
        tmo_cnt <= '0;
      end
      if (finish) begin
        status.success <= done_ok;
        status.num_retrans <= num_retrans;
        num_retrans <= '0;
        retrans_in_progress <= 1'b0;
        state <= ST_IDLE;
      end else if (retry) begin
        num_retrans <= num_retrans + 1'b1;
        state <= ST_BACKOFF;
      end else begin
        case (state)
          ST_IDLE: begin
            if (tx_start) begin
              retrans_in_progress <= 1'b1;
              state <= ST_WAIT_SIG;
            end
          end
          ST_WAIT_SIG: begin
            if (sig_seen) begin
              state <= ST_WAIT_ACK;
            end
          end
          // retransmitted frame comes back through idle
          ST_BACKOFF: begin
            if (backoff_done) begin
              start_retrans <= 1'b1;
              state <= ST_IDLE;
            end
          end
          default: ;
        endcase
      end
    end
  end

  // one outcome per attempt, and a retry keeps the attempt open
  a_one_outcome: assert property (@(posedge clk) disable iff (!rstn)
    retrans_trigger |-> !tx_try_complete && retrans_in_progress);

endmodule

`default_nettype wire

//--- design/ctl_cfg_pkg.sv
// apb request/response structs, register offsets, configuration and tx status structs
`default_nettype none

package ctl_cfg_pkg;

  typedef struct packed {
    logic psel;
    logic penable;
    logic pwrite;
    logic [7:0] paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic pready;
    logic pslverr;
  } apb_rsp_t;

  // register map, byte offsets
  localparam logic [7:0] REG_MAC_LO = 8'h00;
  localparam logic [7:0] REG_MAC_HI = 8'h04;
  // sifs [6:0], preamble+sig [14:8], symbol [20:16]
  localparam logic [7:0] REG_TIMING = 8'h08;
  localparam logic [7:0] REG_ACK_WAIT = 8'h0c;
  localparam logic [7:0] REG_SIG_TO = 8'h10;
  localparam logic [7:0] REG_ACK_TO = 8'h14;
  // retry limit [3:0], ack_disable [8], cts_disable [9]
  localparam logic [7:0] REG_CTRL = 8'h18;
  // read only
  localparam logic [7:0] REG_STATUS = 8'h1c;

  // all times in clock cycles
  typedef struct packed {
    logic [47:0] self_mac;
    logic [6:0] sifs_time;
    logic [6:0] preamble_sig_time;
    logic [4:0] ofdm_symbol_time;
    logic [14:0] send_ack_wait;
    logic [14:0] sig_valid_timeout;
    logic [14:0] ack_timeout;
    logic [3:0] retrans_limit;
    logic ack_disable;
    logic cts_disable;
  } ctl_cfg_t;

  typedef struct packed {
    logic success;
    logic [3:0] num_retrans;
  } tx_status_t;

endpackage

`default_nettype wire

//--- design/ctl_regs.sv
// apb slave register block, configuration registers and tx status readback
`default_nettype none

module ctl_regs #(
  parameter int COUNT_WIDTH = 15,
  parameter int RETRY_WIDTH = 4
) (
  input wire clk,
  input wire rstn,
  input wire ctl_cfg_pkg::apb_req_t req,
  output ctl_cfg_pkg::apb_rsp_t rsp,
  input wire ctl_cfg_pkg::tx_status_t status,
  output ctl_cfg_pkg::ctl_cfg_t cfg
);
  import ctl_cfg_pkg::*;

  logic access;
  logic mapped;
  logic [31:0] rdata;

  // access phase, no wait states
  assign access = req.psel && req.penable;

  // address decode and read mux
  always_comb begin
    mapped = 1'b1;
    rdata = '0;
    case (req.paddr)
      REG_MAC_LO: rdata = cfg.self_mac[31:0];
      REG_MAC_HI: rdata = {16'd0, cfg.self_mac[47:32]};
      REG_TIMING: rdata = {11'd0, cfg.ofdm_symbol_time, 1'b0, cfg.preamble_sig_time,
                           1'b0, cfg.sifs_time};
      REG_ACK_WAIT: rdata = {17'd0, cfg.send_ack_wait};
      REG_SIG_TO: rdata = {17'd0, cfg.sig_valid_timeout};
      REG_ACK_TO: rdata = {17'd0, cfg.ack_timeout};
      REG_CTRL: rdata = {22'd0, cfg.cts_disable, cfg.ack_disable, 4'd0, cfg.retrans_limit};
      REG_STATUS: rdata = {27'd0, status};
      default: mapped = 1'b0;
    endcase
  end

  assign rsp.prdata = rdata;
  assign rsp.pready = 1'b1;
  // unmapped offset, error and no side effect
  assign rsp.pslverr = access && !mapped;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      cfg <= '0;
    end else if (access && req.pwrite) begin
      case (req.paddr)
        REG_MAC_LO: cfg.self_mac[31:0] <= req.pwdata;
        REG_MAC_HI: cfg.self_mac[47:32] <= req.pwdata[15:0];
        REG_TIMING: begin
          cfg.sifs_time <= req.pwdata[6:0];
          cfg.preamble_sig_time <= req.pwdata[14:8];
          cfg.ofdm_symbol_time <= req.pwdata[20:16];
        end
        REG_ACK_WAIT: cfg.send_ack_wait <= req.pwdata[COUNT_WIDTH-1:0];
        REG_SIG_TO: cfg.sig_valid_timeout <= req.pwdata[COUNT_WIDTH-1:0];
        REG_ACK_TO: cfg.ack_timeout <= req.pwdata[COUNT_WIDTH-1:0];
        REG_CTRL: begin
          cfg.retrans_limit <= req.pwdata[RETRY_WIDTH-1:0];
          cfg.ack_disable <= req.pwdata[8];
          cfg.cts_disable <= req.pwdata[9];
        end
        // status is read only
        default: ;
      endcase
    end
  end

  // access phase must follow a setup phase of the same transfer
  a_apb_phase: assert property (@(posedge clk) disable iff (!rstn)
    req.penable |-> req.psel && $past(req.psel && !req.penable));

endmodule

`default_nettype wire

//--- design/mac_frame_pkg.sv
// frame-control codes, received-frame metadata, response request and response word layouts
`default_nettype none

package mac_frame_pkg;

  // 802.11 frame type field
  typedef enum logic [1:0] {
    FC_MGMT = 2'b00,
    FC_CTRL = 2'b01,
    FC_DATA = 2'b10
  } fc_type_t;

  // control subtypes
  localparam logic [3:0] SUBTYPE_PSPOLL = 4'b1010;
  localparam logic [3:0] SUBTYPE_RTS = 4'b1011;
  localparam logic [3:0] SUBTYPE_CTS = 4'b1100;
  localparam logic [3:0] SUBTYPE_ACK = 4'b1101;
  // action no-ack, never answered
  localparam logic [3:0] SUBTYPE_MGMT_NOACK = 4'b1110;

  // ack and cts always go out at 6 Mb/s
  localparam logic [11:0] ACK_SIGNAL_LEN = 12'd14;
  localparam logic [3:0] ACK_RATE_CODE = 4'b1011;
  localparam int unsigned ACK_NUM_SYM = 6;

  // header fields of a received frame, sampled at the fcs strobe
  typedef struct packed {
    logic fcs_strobe;
    logic fcs_valid;
    fc_type_t fc_type;
    logic [3:0] fc_subtype;
    logic more_frag;
    logic [15:0] duration;
    logic [47:0] addr1;
    logic [47:0] addr2;
    logic [15:0] signal_len;
  } rx_meta_t;

  // classifier to responder
  typedef struct packed {
    logic valid;
    logic is_cts;
    logic [47:0] ra;
    logic [15:0] duration;
  } resp_req_t;

  typedef logic [63:0] phy_word_t;

  // word 0, SIGNAL field in the low bits
  typedef struct packed {
    logic [45:0] rsvd_hi;
    logic parity;
    logic [11:0] len;
    logic rsvd;
    logic [3:0] rate;
  } sig_word_t;

  // word 1, frame control + duration + RA[31:0]
  typedef struct packed {
    logic [31:0] ra_lo;
    logic [15:0] duration;
    logic [7:0] fc_flags;
    logic [3:0] subtype;
    logic [1:0] ftype;
    logic [1:0] version;
  } hdr_word_t;

endpackage

`default_nettype wire

//--- design/rx_frame_classify.sv
// stage 1, response decision, response duration and incoming ack detection
`default_nettype none

module rx_frame_classify (
  input wire clk,
  input wire rstn,
  input wire mac_frame_pkg::rx_meta_t rx,
  input wire sig_valid,
  input wire ctl_cfg_pkg::ctl_cfg_t cfg,
  output mac_frame_pkg::resp_req_t req,
  output logic ack_seen,
  output logic sig_seen
);
  import mac_frame_pkg::*;

  logic to_self;
  logic is_data;
  logic is_mgmt;
  logic is_pspoll;
  logic is_rts;
  logic is_ack;
  logic len_is_ack;
  logic need_resp;
  logic dur_from_rx;
  logic [9:0] air_time;
  logic [9:0] resp_overhead;
  logic [15:0] dur_left;
  logic [15:0] dur_calc;

  // frame decode
  assign to_self = (rx.addr1 == cfg.self_mac);
  assign len_is_ack = (rx.signal_len == 16'(ACK_SIGNAL_LEN));
  assign is_data = (rx.fc_type == FC_DATA);
  assign is_mgmt = (rx.fc_type == FC_MGMT) && (rx.fc_subtype != SUBTYPE_MGMT_NOACK);
  assign is_pspoll = (rx.fc_type == FC_CTRL) && (rx.fc_subtype == SUBTYPE_PSPOLL);
  assign is_rts = (rx.fc_type == FC_CTRL) && (rx.fc_subtype == SUBTYPE_RTS);
  assign is_ack = (rx.fc_type == FC_CTRL) && (rx.fc_subtype == SUBTYPE_ACK) && len_is_ack;

  // answered frames: data, mgmt, ps-poll, rts unless cts is off
  assign need_resp = rx.fcs_strobe && rx.fcs_valid && to_self && !cfg.ack_disable &&
                     (is_data || is_mgmt || is_pspoll || (is_rts && !cfg.cts_disable));

  // response airtime + sifs, config is static so two stages are fine
  always_ff @(posedge clk) begin
    air_time <= 10'(cfg.preamble_sig_time) + 10'(cfg.ofdm_symbol_time) * 10'(ACK_NUM_SYM);
    resp_overhead <= air_time + 10'(cfg.sifs_time);
  end

  // duration only carried over for rts and fragment bursts
  assign dur_from_rx = is_rts || ((is_data || is_mgmt) && rx.more_frag);
  assign dur_left = rx.duration - 16'(resp_overhead);

  always_comb begin
    dur_calc = '0;
    // bit 15 set means aid, not a duration
    if (!rx.duration[15] && dur_from_rx && (rx.duration > 16'(resp_overhead))) begin
      dur_calc = dur_left;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      req.valid <= 1'b0;
      ack_seen <= 1'b0;
      sig_seen <= 1'b0;
    end else begin
      req.valid <= need_resp;
      ack_seen <= rx.fcs_strobe && rx.fcs_valid && to_self && is_ack;
      // sig of ack length, start of a possible ack
      sig_seen <= sig_valid && len_is_ack;
      // payload held until the next strobe
      if (rx.fcs_strobe) begin
        req.is_cts <= is_rts;
        req.ra <= rx.addr2;
        req.duration <= dur_calc;
      end
    end
  end

endmodule

`default_nettype wire

//--- design/tx_control_top.sv
// top level, register block plus classify, respond and ack-wait stages
`default_nettype none

module tx_control_top #(
  parameter int COUNT_WIDTH = 15,
  parameter int RETRY_WIDTH = 4
) (
  input wire clk,
  input wire rstn,
  input wire ctl_cfg_pkg::apb_req_t apb_req,
  output ctl_cfg_pkg::apb_rsp_t apb_rsp,
  input wire mac_frame_pkg::rx_meta_t rx,
  input wire sig_valid,
  output mac_frame_pkg::phy_word_t word,
  output logic word_valid,
  input wire word_ready,
  output logic ack_cts_busy,
  input wire tx_done,
  input wire tx_need_ack,
  input wire backoff_done,
  input wire quit_retrans,
  output logic tx_try_complete,
  output logic retrans_trigger,
  output logic start_retrans,
  output logic retrans_in_progress
);
  import ctl_cfg_pkg::*;
  import mac_frame_pkg::*;

  ctl_cfg_t cfg;
  tx_status_t status;
  resp_req_t resp_req;
  // stage 1 to stage 3
  logic ack_seen;
  logic sig_seen;

  ctl_regs #(
    .COUNT_WIDTH(COUNT_WIDTH),
    .RETRY_WIDTH(RETRY_WIDTH)
  ) regs0 (
    .clk(clk),
    .rstn(rstn),
    .req(apb_req),
    .rsp(apb_rsp),
    .status(status),
    .cfg(cfg)
  );

  rx_frame_classify classify0 (
    .clk(clk),
    .rstn(rstn),
    .rx(rx),
    .sig_valid(sig_valid),
    .cfg(cfg),
    .req(resp_req),
    .ack_seen(ack_seen),
    .sig_seen(sig_seen)
  );

  ack_responder #(
    .COUNT_WIDTH(COUNT_WIDTH)
  ) responder0 (
    .clk(clk),
    .rstn(rstn),
    .req(resp_req),
    .cfg(cfg),
    .word(word),
    .word_valid(word_valid),
    .word_ready(word_ready),
    .ack_cts_busy(ack_cts_busy)
  );

  ack_wait_tracker #(
    .COUNT_WIDTH(COUNT_WIDTH),
    .RETRY_WIDTH(RETRY_WIDTH)
  ) tracker0 (
    .clk(clk),
    .rstn(rstn),
    .cfg(cfg),
    .tx_done(tx_done),
    .tx_need_ack(tx_need_ack),
    .sig_seen(sig_seen),
    .ack_seen(ack_seen),
    .backoff_done(backoff_done),
    .quit_retrans(quit_retrans),
    .ack_cts_busy(ack_cts_busy),
    .tx_try_complete(tx_try_complete),
    .retrans_trigger(retrans_trigger),
    .start_retrans(start_retrans),
    .retrans_in_progress(retrans_in_progress),
    .status(status)
  );

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the tx control testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_tx_control -f verilog.f

out=$(./obj_dir/Vtb_tx_control)
echo "$out"

# pass only when the testbench printed its pass line
grep -q '^>>> PASS$' <<< "$out"

//--- verilog.f
design/mac_frame_pkg.sv
design/ctl_cfg_pkg.sv
design/ctl_regs.sv
design/rx_frame_classify.sv
design/ack_responder.sv
design/ack_wait_tracker.sv
design/tx_control_top.sv
bench/tb_tx_control.sv
